//--- rtl/cpu_settings.svh
`ifndef CPU_SETTINGS_SVH
`define CPU_SETTINGS_SVH

// Datapath word and register numbering
`define DATA_WIDTH 32
`define REG_ADDR_BITS 5
`define NUM_REGS 32

// Instruction and data memories share one size
`define MEM_DEPTH_LOG2 6
`define MEM_DEPTH 64

`define RESET_PC 32'h0000_0000

`endif

//--- rtl/cpu_pkg.sv
`default_nettype none

`include "cpu_settings.svh"

package cpu_pkg;

  typedef enum logic [2:0] {
    alu_add,
    alu_sub,
    alu_and,
    alu_or,
    alu_slt
  } alu_op_t;

  typedef enum logic [5:0] {
    op_rtype = 6'h00,
    op_beq   = 6'h04,
    op_addi  = 6'h08,
    op_lw    = 6'h23,
    op_sw    = 6'h2b
  } opcode_t;

  typedef struct packed {
    logic [`DATA_WIDTH-1:0] pc_plus4;
    logic [`DATA_WIDTH-1:0] instruction;
  } if_id_t;

  typedef struct packed {
    logic [`DATA_WIDTH-1:0] pc_plus4;
    logic [`REG_ADDR_BITS-1:0] rs;
    logic [`REG_ADDR_BITS-1:0] rt;
    logic [`REG_ADDR_BITS-1:0] rd_sel;
    logic [`DATA_WIDTH-1:0] rs_data;
    logic [`DATA_WIDTH-1:0] rt_data;
    logic [`DATA_WIDTH-1:0] immediate;
    alu_op_t alu_op;
    logic alu_src; // Immediate as second operand
    logic mem_read;
    logic mem_write;
    logic reg_write;
    logic branch;
  } id_ex_t;

  typedef struct packed {
    logic [`DATA_WIDTH-1:0] alu_result;
    logic [`DATA_WIDTH-1:0] store_data;
    logic [`REG_ADDR_BITS-1:0] rd_sel;
    logic mem_read;
    logic mem_write;
    logic reg_write;
  } ex_mem_t;

  typedef struct packed {
    logic [`DATA_WIDTH-1:0] alu_result;
    logic [`DATA_WIDTH-1:0] read_data;
    logic [`REG_ADDR_BITS-1:0] rd_sel;
    logic mem_to_reg;
    logic reg_write;
  } mem_wb_t;

endpackage

`default_nettype wire

//--- rtl/regfile_if.sv
`timescale 1ns/1ps
`default_nettype none

`include "cpu_settings.svh"

interface regfile_if;

  logic [`REG_ADDR_BITS-1:0] rs_addr;
  logic [`REG_ADDR_BITS-1:0] rt_addr;
  logic [`DATA_WIDTH-1:0]    rs_data;
  logic [`DATA_WIDTH-1:0]    rt_data;

  modport reader (output rs_addr, rt_addr, input rs_data, rt_data);
  modport file (input rs_addr, rt_addr, output rs_data, rt_data);

endinterface

`default_nettype wire

//--- rtl/pipe_reg.sv
`timescale 1ns/1ps
`default_nettype none

module pipe_reg #(
  parameter type payload_t = logic
) (
  input  logic     clk,
  input  logic     reset,
  input  logic     hold,
  input  logic     flush,
  input  payload_t d,
  output payload_t q
);

  // Zero payload is a bubble; flush beats hold
  always_ff @(posedge clk) begin
    if (reset || flush) begin
      q <= '0;
    end else if (!hold) begin
      q <= d;
    end
  end

endmodule

`default_nettype wire

//--- rtl/fetch_stage.sv
`timescale 1ns/1ps
`default_nettype none

`include "cpu_settings.svh"

module fetch_stage import cpu_pkg::*; (
  input  logic                       clk,
  input  logic                       reset,
  input  logic                       hold,
  input  logic                       branch_taken,
  input  logic [`DATA_WIDTH-1:0]     branch_target,
  input  logic                       imem_write,
  input  logic [`MEM_DEPTH_LOG2-1:0] imem_addr,
  input  logic [`DATA_WIDTH-1:0]     imem_data,
  output if_id_t                     if_out
);

  logic [`DATA_WIDTH-1:0] pc;
  logic [`DATA_WIDTH-1:0] imem [`MEM_DEPTH];

  // Unloaded words decode as no-op
  initial begin
    for (int i = 0; i < `MEM_DEPTH; i++) begin
      imem[i] = '0;
    end
  end

  always_ff @(posedge clk) begin
    if (reset && imem_write) begin // Program load only during reset
      imem[imem_addr] <= imem_data;
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      pc <= `RESET_PC;
    end else if (branch_taken) begin // Redirect wins over stall
      pc <= branch_target;
    end else if (!hold) begin
      pc <= pc + 4;
    end
  end

  assign if_out.pc_plus4    = pc + 4;
  assign if_out.instruction = imem[pc[`MEM_DEPTH_LOG2+1:2]];

endmodule

`default_nettype wire

//--- rtl/decode_stage.sv
`timescale 1ns/1ps
`default_nettype none

`include "cpu_settings.svh"

module decode_stage import cpu_pkg::*; (
  input  if_id_t                    if_in,
  input  logic                      ex_mem_read,
  input  logic [`REG_ADDR_BITS-1:0] ex_rt,
  regfile_if.reader                 rf,
  output id_ex_t                    id_out,
  output logic                      load_use_stall
);

  localparam logic [5:0] funct_add = 6'h20;
  localparam logic [5:0] funct_sub = 6'h22;
  localparam logic [5:0] funct_and = 6'h24;
  localparam logic [5:0] funct_or  = 6'h25;
  localparam logic [5:0] funct_slt = 6'h2a;

  opcode_t                   opcode;
  logic [`REG_ADDR_BITS-1:0] rs;
  logic [`REG_ADDR_BITS-1:0] rt;
  logic [`REG_ADDR_BITS-1:0] rd;
  logic [5:0]                funct;
  logic                      uses_rt;

  assign opcode = opcode_t'(if_in.instruction[31:26]);
  assign rs     = if_in.instruction[25:21];
  assign rt     = if_in.instruction[20:16];
  assign rd     = if_in.instruction[15:11];
  assign funct  = if_in.instruction[5:0];

  assign rf.rs_addr = rs;
  assign rf.rt_addr = rt;

  always_comb begin
    id_out           = '0;
    id_out.pc_plus4  = if_in.pc_plus4;
    id_out.rs        = rs;
    id_out.rt        = rt;
    id_out.rs_data   = rf.rs_data;
    id_out.rt_data   = rf.rt_data;
    id_out.immediate = {{(`DATA_WIDTH-16){if_in.instruction[15]}}, if_in.instruction[15:0]};
    uses_rt          = 1'b0;
    case (opcode)
      op_rtype: begin
        id_out.rd_sel    = rd;
        id_out.reg_write = 1'b1;
        uses_rt          = 1'b1;
        case (funct)
          funct_add: id_out.alu_op = alu_add;
          funct_sub: id_out.alu_op = alu_sub;
          funct_and: id_out.alu_op = alu_and;
          funct_or:  id_out.alu_op = alu_or;
          funct_slt: id_out.alu_op = alu_slt;
          default:   id_out.reg_write = 1'b0; // Unknown funct including the all-zero word
        endcase
      end
      op_addi: begin
        id_out.rd_sel    = rt;
        id_out.alu_src   = 1'b1;
        id_out.reg_write = 1'b1;
      end
      op_lw: begin
        id_out.rd_sel    = rt;
        id_out.alu_src   = 1'b1;
        id_out.mem_read  = 1'b1;
        id_out.reg_write = 1'b1;
      end
      op_sw: begin
        id_out.alu_src   = 1'b1;
        id_out.mem_write = 1'b1;
        uses_rt          = 1'b1; // Store data
      end
      op_beq: begin
        id_out.alu_op = alu_sub;
        id_out.branch = 1'b1;
        uses_rt       = 1'b1;
      end
      default: ;
    endcase
  end

  // Load in execute feeds this instruction
  assign load_use_stall = ex_mem_read && (ex_rt != '0) &&
                          ((ex_rt == rs) || (uses_rt && (ex_rt == rt)));

endmodule

`default_nettype wire

//--- rtl/execute_stage.sv
`timescale 1ns/1ps
`default_nettype none

`include "cpu_settings.svh"

module execute_stage import cpu_pkg::*; (
  input  id_ex_t                 id_in,
  input  ex_mem_t                ex_mem_fwd,
  input  mem_wb_t                mem_wb_fwd,
  output ex_mem_t                ex_out,
  output logic                   branch_taken,
  output logic [`DATA_WIDTH-1:0] branch_target
);

  logic [`DATA_WIDTH-1:0] op_a;
  logic [`DATA_WIDTH-1:0] rt_val;
  logic [`DATA_WIDTH-1:0] op_b;
  logic [`DATA_WIDTH-1:0] result;

  // Youngest producer first
  function automatic logic [`DATA_WIDTH-1:0] forward(
    input logic [`REG_ADDR_BITS-1:0] src,
    input logic [`DATA_WIDTH-1:0]    file_val,
    input ex_mem_t                   em,
    input mem_wb_t                   mw
  );
    if (em.reg_write && (em.rd_sel != '0) && (em.rd_sel == src)) begin
      return em.alu_result;
    end else if (mw.reg_write && (mw.rd_sel != '0) && (mw.rd_sel == src)) begin
      return mw.mem_to_reg ? mw.read_data : mw.alu_result;
    end
    return file_val;
  endfunction

  assign op_a   = forward(id_in.rs, id_in.rs_data, ex_mem_fwd, mem_wb_fwd);
  assign rt_val = forward(id_in.rt, id_in.rt_data, ex_mem_fwd, mem_wb_fwd);
  assign op_b   = id_in.alu_src ? id_in.immediate : rt_val;

  always_comb begin
    case (id_in.alu_op)
      alu_add: result = op_a + op_b;
      alu_sub: result = op_a - op_b;
      alu_and: result = op_a & op_b;
      alu_or:  result = op_a | op_b;
      alu_slt: result = {{(`DATA_WIDTH-1){1'b0}}, $signed(op_a) < $signed(op_b)};
      default: result = '0;
    endcase
  end

  always_comb begin
    ex_out            = '0;
    ex_out.alu_result = result;
    ex_out.store_data = rt_val; // Forwarded store data
    ex_out.rd_sel     = id_in.rd_sel;
    ex_out.mem_read   = id_in.mem_read;
    ex_out.mem_write  = id_in.mem_write;
    ex_out.reg_write  = id_in.reg_write;
  end

  assign branch_taken  = id_in.branch && (op_a == rt_val);
  assign branch_target = id_in.pc_plus4 + {id_in.immediate[`DATA_WIDTH-3:0], 2'b00};

endmodule

`default_nettype wire

//--- rtl/memory_stage.sv
`timescale 1ns/1ps
`default_nettype none

`include "cpu_settings.svh"

module memory_stage import cpu_pkg::*; (
  input  logic                   clk,
  input  ex_mem_t                ex_in,
  output mem_wb_t                mem_out,
  output logic                   mem_write,
  output logic [`DATA_WIDTH-1:0] mem_addr,
  output logic [`DATA_WIDTH-1:0] mem_data
);

  logic [`DATA_WIDTH-1:0]    dmem [`MEM_DEPTH];
  logic [`MEM_DEPTH_LOG2-1:0] word_idx;

  initial begin
    for (int i = 0; i < `MEM_DEPTH; i++) begin
      dmem[i] = '0;
    end
  end

  assign word_idx = ex_in.alu_result[`MEM_DEPTH_LOG2+1:2]; // Byte address to word

  always_ff @(posedge clk) begin
    if (ex_in.mem_write) begin
      dmem[word_idx] <= ex_in.store_data;
    end
  end

  assign mem_write = ex_in.mem_write;
  assign mem_addr  = ex_in.alu_result;
  assign mem_data  = ex_in.store_data;

  assign mem_out.alu_result = ex_in.alu_result;
  assign mem_out.read_data  = dmem[word_idx];
  assign mem_out.rd_sel     = ex_in.rd_sel;
  assign mem_out.mem_to_reg = ex_in.mem_read;
  assign mem_out.reg_write  = ex_in.reg_write;

endmodule

`default_nettype wire

//--- rtl/register_file.sv
`timescale 1ns/1ps
`default_nettype none

`include "cpu_settings.svh"

module register_file import cpu_pkg::*; (
  input  logic                      clk,
  input  logic                      reset,
  input  mem_wb_t                   wb_in,
  regfile_if.file                   rf,
  output logic                      wb_valid,
  output logic [`REG_ADDR_BITS-1:0] wb_reg,
  output logic [`DATA_WIDTH-1:0]    wb_data
);

  logic [`DATA_WIDTH-1:0] regs [`NUM_REGS];
  logic [`DATA_WIDTH-1:0] wb_value;
  logic                   write_en;

  assign wb_value = wb_in.mem_to_reg ? wb_in.read_data : wb_in.alu_result;
  assign write_en = wb_in.reg_write && (wb_in.rd_sel != '0); // r0 stays zero

  always_ff @(posedge clk) begin
    if (reset) begin
      for (int i = 0; i < `NUM_REGS; i++) begin
        regs[i] <= '0;
      end
    end else if (write_en) begin
      regs[wb_in.rd_sel] <= wb_value;
    end
  end

  // Write-through so decode sees the value retiring this cycle
  assign rf.rs_data = (write_en && (wb_in.rd_sel == rf.rs_addr)) ? wb_value : regs[rf.rs_addr];
  assign rf.rt_data = (write_en && (wb_in.rd_sel == rf.rt_addr)) ? wb_value : regs[rf.rt_addr];

  assign wb_valid = write_en;
  assign wb_reg   = wb_in.rd_sel;
  assign wb_data  = wb_value;

endmodule

`default_nettype wire

//--- rtl/mips_pipeline_top.sv
`timescale 1ns/1ps
`default_nettype none

`include "cpu_settings.svh"

module mips_pipeline_top import cpu_pkg::*; (
  input  logic                       clk,
  input  logic                       reset,
  input  logic                       imem_write,
  input  logic [`MEM_DEPTH_LOG2-1:0] imem_addr,
  input  logic [`DATA_WIDTH-1:0]     imem_data,
  output logic                       wb_valid,
  output logic [`REG_ADDR_BITS-1:0]  wb_reg,
  output logic [`DATA_WIDTH-1:0]     wb_data,
  output logic                       mem_write,
  output logic [`DATA_WIDTH-1:0]     mem_addr,
  output logic [`DATA_WIDTH-1:0]     mem_data
);

  if_id_t  if_id_d, if_id_q;
  id_ex_t  id_ex_d, id_ex_q;
  ex_mem_t ex_mem_d, ex_mem_q;
  mem_wb_t mem_wb_d, mem_wb_q;

  logic                   load_use_stall;
  logic                   branch_taken;
  logic [`DATA_WIDTH-1:0] branch_target;

  regfile_if rf_bus ();

  fetch_stage u_fetch (.clk, .reset, .hold(load_use_stall), .branch_taken, .branch_target,
                       .imem_write, .imem_addr, .imem_data, .if_out(if_id_d));

  pipe_reg #(.payload_t(if_id_t)) u_if_id (.clk, .reset, .hold(load_use_stall),
                                           .flush(branch_taken), .d(if_id_d), .q(if_id_q));

  decode_stage u_decode (.if_in(if_id_q), .ex_mem_read(id_ex_q.mem_read), .ex_rt(id_ex_q.rt),
                         .rf(rf_bus.reader), .id_out(id_ex_d), .load_use_stall);

  // Stall turns the decode slot into a bubble
  pipe_reg #(.payload_t(id_ex_t)) u_id_ex (.clk, .reset, .hold(1'b0),
                                           .flush(branch_taken || load_use_stall),
                                           .d(id_ex_d), .q(id_ex_q));

  execute_stage u_execute (.id_in(id_ex_q), .ex_mem_fwd(ex_mem_q), .mem_wb_fwd(mem_wb_q),
                           .ex_out(ex_mem_d), .branch_taken, .branch_target);

  pipe_reg #(.payload_t(ex_mem_t)) u_ex_mem (.clk, .reset, .hold(1'b0), .flush(1'b0),
                                             .d(ex_mem_d), .q(ex_mem_q));

  memory_stage u_memory (.clk, .ex_in(ex_mem_q), .mem_out(mem_wb_d),
                         .mem_write, .mem_addr, .mem_data);

  pipe_reg #(.payload_t(mem_wb_t)) u_mem_wb (.clk, .reset, .hold(1'b0), .flush(1'b0),
                                             .d(mem_wb_d), .q(mem_wb_q));

  register_file u_register_file (.clk, .reset, .wb_in(mem_wb_q), .rf(rf_bus.file),
                                 .wb_valid, .wb_reg, .wb_data);

endmodule

`default_nettype wire

//--- verif/mips_pipeline_properties.sv
`timescale 1ns/1ps
`default_nettype none

`include "cpu_settings.svh"

module mips_pipeline_properties import cpu_pkg::*; (
  input logic                      clk,
  input logic                      reset,
  input logic                      wb_valid,
  input logic [`REG_ADDR_BITS-1:0] wb_reg,
  input logic                      mem_write,
  input logic                      branch_taken,
  input id_ex_t                    id_ex_q
);

  int failures = 0;

  assert property (@(posedge clk) disable iff (reset) wb_valid |-> wb_reg != '0)
    else begin
      failures++;
      $error("write-back reported for register 0");
    end

  assert property (@(posedge clk) reset |=> !wb_valid && !mem_write)
    else begin
      failures++;
      $error("write-back or store strobe active right after reset");
    end

  // Wrong-path decode slot squashed
  assert property (@(posedge clk) disable iff (reset) branch_taken |=> id_ex_q == '0)
    else begin
      failures++;
      $error("execute stage not emptied after a taken branch");
    end

endmodule

bind mips_pipeline_top mips_pipeline_properties u_properties (
  .clk, .reset, .wb_valid, .wb_reg, .mem_write, .branch_taken, .id_ex_q
);

`default_nettype wire

//--- verif/mips_pipeline_tb.sv
`timescale 1ns/1ps
`default_nettype none

`include "cpu_settings.svh"

module mips_pipeline_tb import cpu_pkg::*; ;

  localparam int num_tests   = 6;
  localparam int max_prog    = `MEM_DEPTH;
  localparam int watchdog_ns = num_tests * 3 * (max_prog + 10) * 20;
  localparam logic [31:0] halt_word = 32'h1000_ffff; // beq r0, r0, -1

  logic                       clk;
  logic                       reset;
  logic                       imem_write;
  logic [`MEM_DEPTH_LOG2-1:0] imem_addr;
  logic [`DATA_WIDTH-1:0]     imem_data;
  logic                       wb_valid;
  logic [`REG_ADDR_BITS-1:0]  wb_reg;
  logic [`DATA_WIDTH-1:0]     wb_data;
  logic                       mem_write;
  logic [`DATA_WIDTH-1:0]     mem_addr;
  logic [`DATA_WIDTH-1:0]     mem_data;

  logic [31:0] prog [max_prog];
  int          prog_len;
  logic [31:0] model_mem [`MEM_DEPTH]; // Data RAM keeps its contents across resets
  logic [36:0] exp_wb [$];             // {reg, data}
  logic [63:0] exp_st [$];             // {addr, data}
  int          test_errors;
  int          total_errors;
  int          failed_tests;

  mips_pipeline_top u_mips_pipeline_top (.clk, .reset, .imem_write, .imem_addr, .imem_data,
                                         .wb_valid, .wb_reg, .wb_data,
                                         .mem_write, .mem_addr, .mem_data);

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  initial begin
    #(watchdog_ns);
    $display("Watchdog expired before all tests finished");
    $display("=== FAIL ===");
    $finish;
  end

  function automatic logic [31:0] r_type(input logic [5:0] funct, input int rd, input int rs,
                                         input int rt);
    return {6'h00, 5'(rs), 5'(rt), 5'(rd), 5'h00, funct};
  endfunction

  function automatic logic [31:0] i_type(input logic [5:0] op, input int rt, input int rs,
                                         input int imm);
    return {op, 5'(rs), 5'(rt), 16'(imm)};
  endfunction

  function automatic int pick_reg();
    return $urandom_range(0, 7); // Small set to force dependencies
  endfunction

  task automatic emit(input logic [31:0] word);
    prog[prog_len] = word;
    prog_len++;
  endtask

  task automatic check(input string name, input logic [31:0] got, input logic [31:0] want);
    if (got !== want) begin
      $display("** Error: %s is 0x%h, expected 0x%h", name, got, want);
      test_errors++;
    end
  endtask

  // Architectural execution up to the halt word
  function automatic void model_run();
    logic [31:0] regs [32];
    logic [31:0] ins;
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] imm;
    logic [31:0] addr;
    logic [31:0] res;
    int          dest;
    int          pc;
    int          steps;
    for (int i = 0; i < 32; i++) begin
      regs[i] = '0;
    end
    pc = 0;
    steps = 0;
    while (pc < max_prog && prog[pc] != halt_word && steps < 1000) begin
      ins = prog[pc];
      a = regs[ins[25:21]];
      b = regs[ins[20:16]];
      imm = {{16{ins[15]}}, ins[15:0]};
      addr = a + imm;
      dest = -1;
      res = '0;
      pc++;
      steps++;
      case (ins[31:26])
        op_rtype: begin
          dest = int'(ins[15:11]);
          case (ins[5:0])
            6'h20: res = a + b;
            6'h22: res = a - b;
            6'h24: res = a & b;
            6'h25: res = a | b;
            6'h2a: res = {31'b0, $signed(a) < $signed(b)};
            default: dest = -1; // No-op
          endcase
        end
        op_addi: begin
          dest = int'(ins[20:16]);
          res = addr;
        end
        op_lw: begin
          dest = int'(ins[20:16]);
          res = model_mem[addr[`MEM_DEPTH_LOG2+1:2]];
        end
        op_sw: begin
          model_mem[addr[`MEM_DEPTH_LOG2+1:2]] = b;
          exp_st.push_back({addr, b});
        end
        op_beq: begin
          if (a == b) begin
            pc = pc + $signed(imm);
          end
        end
        default: ;
      endcase
      if (dest > 0) begin
        regs[dest] = res;
        exp_wb.push_back({5'(dest), res});
      end
    end
  endfunction

  initial begin : compare_events
    logic [36:0] wexp;
    logic [63:0] sexp;
    forever begin
      @(negedge clk);
      if (wb_valid === 1'b1) begin
        if (exp_wb.size() == 0) begin
          $display("Unexpected register write to r%0d", wb_reg);
          test_errors++;
        end else begin
          wexp = exp_wb.pop_front();
          check("wb_reg", 32'(wb_reg), 32'(wexp[36:32]));
          check("wb_data", wb_data, wexp[31:0]);
        end
      end
      if (mem_write === 1'b1) begin
        if (exp_st.size() == 0) begin
          $display("Unexpected store to address 0x%h", mem_addr);
          test_errors++;
        end else begin
          sexp = exp_st.pop_front();
          check("mem_addr", mem_addr, sexp[63:32]);
          check("mem_data", mem_data, sexp[31:0]);
        end
      end
    end
  end

  task automatic run_test(input string name);
    int cycles;
    emit(halt_word);
    model_run();
    @(negedge clk);
    test_errors = 0;
    reset = 1'b1;
    for (int i = 0; i < prog_len; i++) begin
      imem_write = 1'b1;
      imem_addr = 6'(i);
      imem_data = prog[i];
      @(negedge clk);
    end
    imem_write = 1'b0;
    repeat (5) @(negedge clk);
    reset = 1'b0;
    cycles = 0;
    while ((exp_wb.size() != 0 || exp_st.size() != 0) && cycles < 3 * (prog_len + 10)) begin
      @(negedge clk);
      cycles++;
    end
    repeat (8) @(negedge clk); // Room for stray late events
    if (exp_wb.size() != 0 || exp_st.size() != 0) begin
      $display("%0d writes and %0d stores never appeared", exp_wb.size(), exp_st.size());
      test_errors++;
      exp_wb.delete();
      exp_st.delete();
    end
    if (test_errors == 0) begin
      $display("%s: ok", name);
    end else begin
      $display("%s: %0d errors", name, test_errors);
      failed_tests++;
    end
    total_errors += test_errors;
    prog_len = 0;
  endtask

  task automatic build_random(input int count);
    for (int i = 0; i < count; i++) begin
      case ($urandom_range(0, 7))
        0: emit(r_type(6'h20, pick_reg(), pick_reg(), pick_reg()));
        1: emit(r_type(6'h22, pick_reg(), pick_reg(), pick_reg()));
        2: emit(r_type(6'h24, pick_reg(), pick_reg(), pick_reg()));
        3: emit(r_type(6'h25, pick_reg(), pick_reg(), pick_reg()));
        4: emit(r_type(6'h2a, pick_reg(), pick_reg(), pick_reg()));
        5: emit(i_type(op_addi, pick_reg(), pick_reg(), $urandom_range(0, 65535)));
        6: emit(i_type(op_lw, pick_reg(), 0, 4 * $urandom_range(0, 63)));
        default: emit(i_type(op_sw, pick_reg(), 0, 4 * $urandom_range(0, 63)));
      endcase
    end
  endtask

  initial begin
    int assert_fails;
    void'($urandom(32'h55b9_ace4));
    reset = 1'b1;
    imem_write = 1'b0;
    imem_addr = '0;
    imem_data = '0;
    prog_len = 0;
    test_errors = 0;
    total_errors = 0;
    failed_tests = 0;
    for (int i = 0; i < `MEM_DEPTH; i++) begin
      model_mem[i] = '0;
    end

    emit(i_type(op_addi, 1, 0, 5));
    emit(i_type(op_addi, 2, 0, 12));
    emit(r_type(6'h20, 3, 1, 2));
    emit(r_type(6'h22, 4, 3, 1));
    emit(r_type(6'h24, 5, 4, 3));
    emit(r_type(6'h25, 6, 5, 4));
    emit(r_type(6'h20, 7, 6, 3));
    run_test("forwarding");

    emit(i_type(op_addi, 1, 0, -7));
    emit(i_type(op_addi, 2, 1, -100));
    emit(r_type(6'h2a, 3, 2, 1));
    emit(r_type(6'h2a, 4, 1, 2));
    emit(i_type(op_addi, 0, 1, 3)); // r0 target, never reported
    emit(r_type(6'h20, 0, 1, 1));
    emit(i_type(op_addi, 5, 0, 1));
    emit(r_type(6'h2a, 6, 1, 5));
    run_test("immediates_slt");

    emit(i_type(op_addi, 1, 0, 32'h55));
    emit(i_type(op_addi, 2, 0, 16));
    emit(i_type(op_sw, 1, 2, 8));
    emit(i_type(op_lw, 3, 2, 8));
    emit(r_type(6'h20, 4, 3, 1));
    emit(i_type(op_sw, 4, 2, 12));
    emit(i_type(op_lw, 5, 2, 12));
    emit(i_type(op_sw, 5, 0, 0));
    run_test("store_load");

    emit(i_type(op_addi, 1, 0, 3));
    emit(i_type(op_addi, 2, 0, 3));
    emit(i_type(op_beq, 2, 1, 2));
    emit(i_type(op_addi, 3, 0, 1));
    emit(i_type(op_addi, 4, 0, 2));
    emit(i_type(op_addi, 5, 0, 9));
    run_test("branch_taken");

    emit(i_type(op_addi, 1, 0, 1));
    emit(i_type(op_beq, 0, 1, 2));
    emit(i_type(op_addi, 3, 0, 4));
    emit(i_type(op_addi, 4, 3, 1));
    run_test("branch_not_taken");

    build_random(40);
    run_test("random_program");

    assert_fails = u_mips_pipeline_top.u_properties.failures;
    $display("Tests: %0d, failed: %0d, errors: %0d, assertion failures: %0d",
             num_tests, failed_tests, total_errors, assert_fails);
    if (failed_tests == 0 && assert_fails == 0) begin
      $display("=== PASS ===");
    end else begin
      $display("=== FAIL ===");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- src.f
+incdir+rtl
rtl/cpu_pkg.sv
rtl/regfile_if.sv
rtl/pipe_reg.sv
rtl/fetch_stage.sv
rtl/decode_stage.sv
rtl/execute_stage.sv
rtl/memory_stage.sv
rtl/register_file.sv
rtl/mips_pipeline_top.sv
verif/mips_pipeline_properties.sv
verif/mips_pipeline_tb.sv

//--- Makefile
.PHONY: sim clean

sim:
	verilator --binary --timing --assert -f src.f --top-module mips_pipeline_tb --Mdir obj_dir
	./obj_dir/Vmips_pipeline_tb | tee sim.log
	grep -q "^=== PASS ===$$" sim.log

clean:
	rm -rf obj_dir sim.log
